// ==== hdl/fetch_pkg.sv ====
// fetch front end types
package fetch_pkg;

  ////////////////////////////////////////
  // vector types
  ////////////////////////////////////////

  // byte address on the instruction side
  typedef logic [31:0] addr_t;

  // raw memory word as returned by the bus
  typedef logic [31:0] word_t;

  // aligned instruction
  // compressed ones sit in the low half, upper half zero
  typedef logic [31:0] instr_t;

  ////////////////////////////////////////
  // fetch fsm
  ////////////////////////////////////////

  // WAIT_ABORTED swallows the response owed from before a branch
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } fetch_state_e;

endpackage

// ==== hdl/fifo_in_if.sv ====
// fetch fifo input side
`timescale 1ns/100ps

interface fifo_in_if;

  // address slot handshake
  logic             addr_valid;
  logic             addr_ready;
  fetch_pkg::addr_t addr;
  // newest valid address held in the fifo
  fetch_pkg::addr_t last_addr;

  // returned word handshake
  logic             rdata_valid;
  logic             rdata_ready;
  fetch_pkg::word_t rdata;

  // fetch fsm side
  modport fsm (
    output addr_valid, addr, rdata_valid, rdata,
    input  addr_ready, rdata_ready, last_addr
  );

  // fifo side
  modport fifo (
    input  addr_valid, addr, rdata_valid, rdata,
    output addr_ready, rdata_ready, last_addr
  );

endinterface

// ==== hdl/fetch_out_if.sv ====
// buffered word stream to aligner
`timescale 1ns/100ps

interface fetch_out_if;

  // head word and its address
  logic             valid;
  logic             ready;
  fetch_pkg::word_t rdata;
  fetch_pkg::addr_t addr;

  // upper half of head joined with lower half of next word
  logic             unaligned_valid;
  fetch_pkg::word_t unaligned_rdata;

  // prefetch buffer side
  modport buffer (
    output valid, rdata, addr, unaligned_valid, unaligned_rdata,
    input  ready
  );

  // aligner side, only pops
  modport aligner (
    input  valid, rdata, addr, unaligned_valid, unaligned_rdata,
    output ready
  );

endinterface

// ==== hdl/fetch_fifo.sv ====
// fetch address and data fifo
`timescale 1ns/100ps

module fetch_fifo #(
  // two or more, the unaligned view needs a second slot
  parameter int FIFO_DEPTH = 3
) (
  input  logic        clk,
  input  logic        rst_n,
  // drops all content, keeps the address offered this cycle
  input  logic        clear_i,
  fifo_in_if.fifo     in_if,
  fetch_out_if.buffer out_if
);

  // slot 0 is the head in every array
  fetch_pkg::addr_t      addr_q   [FIFO_DEPTH];
  fetch_pkg::addr_t      addr_int [FIFO_DEPTH];
  fetch_pkg::addr_t      addr_d   [FIFO_DEPTH];
  fetch_pkg::word_t      rdata_q   [FIFO_DEPTH];
  fetch_pkg::word_t      rdata_int [FIFO_DEPTH];
  fetch_pkg::word_t      rdata_d   [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0] addr_valid_q;
  logic [FIFO_DEPTH-1:0] addr_valid_int;
  logic [FIFO_DEPTH-1:0] addr_valid_d;
  logic [FIFO_DEPTH-1:0] rdata_valid_q;
  logic [FIFO_DEPTH-1:0] rdata_valid_int;
  logic [FIFO_DEPTH-1:0] rdata_valid_d;

  // word following the head, from slot 1 or straight off the bus
  fetch_pkg::word_t next_word;
  logic             pop;

  ////////////////////////////////////////
  // output views
  ////////////////////////////////////////

  // head data bypasses the registers while it is still on the bus
  assign out_if.rdata = rdata_valid_q[0] ? rdata_q[0] : in_if.rdata;
  assign out_if.addr  = addr_q[0];
  assign out_if.valid = rdata_valid_q[0] | (addr_valid_q[0] & in_if.rdata_valid);

  assign next_word = rdata_valid_q[1] ? rdata_q[1] : in_if.rdata;
  assign out_if.unaligned_rdata = {next_word[15:0], rdata_q[0][31:16]};
  // head word stored and the next one either stored or arriving now
  assign out_if.unaligned_valid = rdata_valid_q[0] &
                                  (rdata_valid_q[1] | (addr_valid_q[1] & in_if.rdata_valid));

  assign pop = out_if.valid & out_if.ready;

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////

  // a clear frees every slot in the same cycle
  assign in_if.addr_ready  = clear_i | ~addr_valid_q[FIFO_DEPTH-1];
  assign in_if.rdata_ready = ~rdata_valid_q[FIFO_DEPTH-1];

  // newest valid address, head if nothing else is valid
  always_comb begin
    in_if.last_addr = addr_q[0];
    for (int i = 1; i < FIFO_DEPTH; i++) begin
      if (addr_valid_q[i]) begin
        in_if.last_addr = addr_q[i];
      end
    end
  end

  // write into the first free slot of each array
  always_comb begin : write_slots
    logic addr_placed;
    logic rdata_placed;
    addr_placed     = 1'b0;
    rdata_placed    = 1'b0;
    addr_int        = addr_q;
    addr_valid_int  = addr_valid_q;
    rdata_int       = rdata_q;
    rdata_valid_int = rdata_valid_q;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      if (in_if.addr_valid && in_if.addr_ready && !addr_placed && !addr_valid_q[i]) begin
        addr_int[i]       = in_if.addr;
        addr_valid_int[i] = 1'b1;
        addr_placed       = 1'b1;
      end
      if (in_if.rdata_valid && in_if.rdata_ready && !rdata_placed && !rdata_valid_q[i]) begin
        rdata_int[i]       = in_if.rdata;
        rdata_valid_int[i] = 1'b1;
        rdata_placed       = 1'b1;
      end
    end
  end

  // pop shifts every slot down by one
  always_comb begin
    addr_d        = addr_int;
    addr_valid_d  = addr_valid_int;
    rdata_d       = rdata_int;
    rdata_valid_d = rdata_valid_int;
    if (pop) begin
      for (int i = 0; i < FIFO_DEPTH-1; i++) begin
        addr_d[i]  = addr_int[i+1];
        rdata_d[i] = rdata_int[i+1];
      end
      addr_d[FIFO_DEPTH-1]  = '0;
      rdata_d[FIFO_DEPTH-1] = '0;
      addr_valid_d  = addr_valid_int >> 1;
      rdata_valid_d = rdata_valid_int >> 1;
    end
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  // addresses feed last_addr and the next fetch address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q        <= '{default: '0};
      addr_valid_q  <= '0;
      rdata_valid_q <= '0;
    end else if (clear_i) begin
      // restart with the branch target as the only entry
      addr_q[0]     <= in_if.addr;
      addr_valid_q  <= {{(FIFO_DEPTH-1){1'b0}}, in_if.addr_valid};
      rdata_valid_q <= '0;
    end else begin
      addr_q        <= addr_d;
      addr_valid_q  <= addr_valid_d;
      rdata_valid_q <= rdata_valid_d;
    end
  end

  // data words, qualified by rdata_valid_q
  always_ff @(posedge clk) begin
    rdata_q <= rdata_d;
  end

endmodule

// ==== hdl/prefetch_buffer.sv ====
// instruction prefetch buffer
`timescale 1ns/100ps

module prefetch_buffer #(
  parameter int FIFO_DEPTH = 3
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_en_i,
  // single cycle flush and restart
  input  logic               branch_i,
  input  fetch_pkg::addr_t   branch_addr_i,
  fetch_out_if.buffer        out_if,
  // instruction memory bus
  output logic               imem_req_o,
  output fetch_pkg::addr_t   imem_addr_o,
  input  logic               imem_gnt_i,
  input  logic               imem_rvalid_i,
  input  fetch_pkg::word_t   imem_rdata_i,
  output logic               busy_o
);

  fetch_pkg::fetch_state_e state_q;
  fetch_pkg::fetch_state_e state_d;
  fetch_pkg::addr_t        addr_next;

  // push strobes toward the fifo
  logic addr_push;
  logic rdata_push;
  // room for one more access
  logic can_issue;

  fifo_in_if fifo_in ();

  ////////////////////////////////////////
  // next address
  ////////////////////////////////////////

  // branch target is word aligned here, the aligner keeps bit 1
  assign addr_next = branch_i ? {branch_addr_i[31:2], 2'b00}
                              : fifo_in.last_addr + 32'd4;

  assign can_issue = fetch_en_i & fifo_in.addr_ready & fifo_in.rdata_ready;

  assign fifo_in.addr_valid  = addr_push;
  assign fifo_in.addr        = addr_next;
  assign fifo_in.rdata_valid = rdata_push;
  assign fifo_in.rdata       = imem_rdata_i;

  assign busy_o = (state_q != fetch_pkg::IDLE) | imem_req_o;

  fetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fetch_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear_i (branch_i),
    .in_if   (fifo_in.fifo),
    .out_if  (out_if)
  );

  ////////////////////////////////////////
  // fetch fsm
  ////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    imem_req_o  = 1'b0;
    imem_addr_o = addr_next;
    addr_push   = 1'b0;
    rdata_push  = 1'b0;

    unique case (state_q)
      // nothing outstanding
      fetch_pkg::IDLE: begin
        if (can_issue || branch_i) begin
          imem_req_o = 1'b1;
          addr_push  = 1'b1;
          state_d    = imem_gnt_i ? fetch_pkg::WAIT_RVALID : fetch_pkg::WAIT_GNT;
        end
      end

      // request up, keep the address until granted
      fetch_pkg::WAIT_GNT: begin
        imem_req_o = 1'b1;
        if (branch_i) begin
          // swap in the target before it is granted
          addr_push = 1'b1;
        end else begin
          imem_addr_o = fifo_in.last_addr;
        end
        if (imem_gnt_i) begin
          state_d = fetch_pkg::WAIT_RVALID;
        end
      end

      // granted, next request only once the word is back
      fetch_pkg::WAIT_RVALID: begin
        if (imem_rvalid_i) begin
          // dropped by the fifo clear on a branch
          rdata_push = 1'b1;
          if (can_issue || branch_i) begin
            imem_req_o = 1'b1;
            addr_push  = 1'b1;
            state_d    = imem_gnt_i ? fetch_pkg::WAIT_RVALID : fetch_pkg::WAIT_GNT;
          end else begin
            state_d = fetch_pkg::IDLE;
          end
        end else if (branch_i) begin
          // park the target, the old word is still owed
          addr_push = 1'b1;
          state_d   = fetch_pkg::WAIT_ABORTED;
        end
      end

      // stale response pending, target already in the fifo
      fetch_pkg::WAIT_ABORTED: begin
        if (branch_i) begin
          addr_push = 1'b1;
        end else begin
          imem_addr_o = fifo_in.last_addr;
        end
        // request in the cycle the stale word drains
        if (imem_rvalid_i) begin
          imem_req_o = 1'b1;
          state_d    = imem_gnt_i ? fetch_pkg::WAIT_RVALID : fetch_pkg::WAIT_GNT;
        end
      end

      default: begin
        state_d = fetch_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== hdl/instr_aligner.sv ====
// compressed instruction aligner
`timescale 1ns/100ps

module instr_aligner (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               branch_i,
  input  fetch_pkg::addr_t   branch_addr_i,
  fetch_out_if.aligner       in_if,
  output logic               instr_valid_o,
  output fetch_pkg::instr_t  instr_o,
  output fetch_pkg::addr_t   pc_o,
  output logic               compressed_o,
  input  logic               instr_ready_i
);

  // 1 when the next instruction starts in the upper half
  logic offset_q;
  logic offset_d;
  // instruction available before the branch gate
  logic avail;
  // delivered instruction ends the head word
  logic pop_head;
  logic fire;

  logic [15:0] lo_half;
  logic [15:0] hi_half;

  assign lo_half = in_if.rdata[15:0];
  assign hi_half = in_if.rdata[31:16];

  // bits 1:0 equal to 11 mark a full length instruction
  always_comb begin
    avail        = in_if.valid;
    instr_o      = in_if.rdata;
    compressed_o = 1'b0;
    pop_head     = 1'b0;
    offset_d     = offset_q;
    if (!offset_q) begin
      if (lo_half[1:0] != 2'b11) begin
        // low half compressed, word stays at the head
        instr_o      = {16'h0000, lo_half};
        compressed_o = 1'b1;
        offset_d     = 1'b1;
      end else begin
        pop_head = 1'b1;
      end
    end else begin
      if (hi_half[1:0] != 2'b11) begin
        instr_o      = {16'h0000, hi_half};
        compressed_o = 1'b1;
        pop_head     = 1'b1;
        offset_d     = 1'b0;
      end else begin
        // straddles into the next word, offset stays 1
        avail    = in_if.valid & in_if.unaligned_valid;
        instr_o  = in_if.unaligned_rdata;
        pop_head = 1'b1;
      end
    end
  end

  // words on the branch cycle are stale
  assign instr_valid_o = avail & ~branch_i;
  assign fire          = instr_valid_o & instr_ready_i;
  assign in_if.ready   = fire & pop_head;

  assign pc_o = in_if.addr + (offset_q ? 32'd2 : 32'd0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      offset_q <= 1'b0;
    end else if (branch_i) begin
      offset_q <= branch_addr_i[1];
    end else if (fire) begin
      offset_q <= offset_d;
    end
  end

endmodule

// ==== hdl/fetch_unit.sv ====
// instruction fetch unit top
`timescale 1ns/100ps

module fetch_unit #(
  // fifo slots, two or more
  parameter int FIFO_DEPTH = 3
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              fetch_en_i,
  input  logic              branch_i,
  input  fetch_pkg::addr_t  branch_addr_i,
  // aligned instruction stream
  output logic              instr_valid_o,
  output fetch_pkg::instr_t instr_o,
  output fetch_pkg::addr_t  pc_o,
  output logic              compressed_o,
  input  logic              instr_ready_i,
  output logic              busy_o,
  // instruction memory bus
  output logic              imem_req_o,
  output fetch_pkg::addr_t  imem_addr_o,
  input  logic              imem_gnt_i,
  input  logic              imem_rvalid_i,
  input  fetch_pkg::word_t  imem_rdata_i
);

  // buffered words toward the aligner
  fetch_out_if fetch_out ();

  prefetch_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_prefetch_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_en_i    (fetch_en_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .out_if        (fetch_out.buffer),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_gnt_i    (imem_gnt_i),
    .imem_rvalid_i (imem_rvalid_i),
    .imem_rdata_i  (imem_rdata_i),
    .busy_o        (busy_o)
  );

  // same branch pulse, loads the halfword offset
  instr_aligner u_instr_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .in_if         (fetch_out.aligner),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .pc_o          (pc_o),
    .compressed_o  (compressed_o),
    .instr_ready_i (instr_ready_i)
  );

endmodule

// ==== verif/fetch_unit_sva.sv ====
// fetch bus and fifo protocol checks
`timescale 1ns/100ps

module fetch_unit_sva (
  input logic clk,
  input logic rst_n,
  input logic imem_req_i,
  input logic imem_gnt_i,
  input logic imem_rvalid_i,
  // word push strobe and its ready flag
  input logic rdata_push_i,
  input logic rdata_ready_i
);

  // one access granted, answer still owed
  logic outstanding_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= 1'b0;
    end else if (imem_req_i && imem_gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (imem_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // instruction bus
  ////////////////////////////////////////

  req_held_a: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req_i && !imem_gnt_i |=> imem_req_i)
    else $error("imem_req_o dropped before imem_gnt_i");

  rvalid_owed_a: assert property (@(posedge clk) disable iff (!rst_n)
    imem_rvalid_i |-> outstanding_q)
    else $error("imem_rvalid_i without an outstanding grant");

  ////////////////////////////////////////
  // fifo writes
  ////////////////////////////////////////

  rdata_room_a: assert property (@(posedge clk) disable iff (!rst_n)
    rdata_push_i |-> rdata_ready_i)
    else $error("word pushed into a full fifo");

endmodule

bind prefetch_buffer fetch_unit_sva u_fetch_unit_sva (
  .clk           (clk),
  .rst_n         (rst_n),
  .imem_req_i    (imem_req_o),
  .imem_gnt_i    (imem_gnt_i),
  .imem_rvalid_i (imem_rvalid_i),
  .rdata_push_i  (rdata_push),
  .rdata_ready_i (fifo_in.rdata_ready)
);

// ==== verif/fetch_unit_tb.sv ====
// fetch unit testbench
`timescale 1ns/100ps

module fetch_unit_tb;

  localparam logic [31:0] LCG_SEED = 32'h148d_3fd4;

  logic              clk;
  logic              rst_n;
  logic              fetch_en_i;
  logic              branch_i;
  fetch_pkg::addr_t  branch_addr_i;
  logic              instr_valid_o;
  fetch_pkg::instr_t instr_o;
  fetch_pkg::addr_t  pc_o;
  logic              compressed_o;
  logic              instr_ready_i;
  logic              busy_o;
  logic              imem_req_o;
  fetch_pkg::addr_t  imem_addr_o;
  logic              imem_gnt_i;
  logic              imem_rvalid_i;
  fetch_pkg::word_t  imem_rdata_i;

  // raw stimulus words, then the parsed image and records
  logic [31:0]       stim [0:127];
  fetch_pkg::word_t  image [0:63];
  int                n_img;
  fetch_pkg::addr_t  rec_target [$];
  int                rec_count [$];
  fetch_pkg::addr_t  exp_pc [$];
  fetch_pkg::instr_t exp_instr [$];
  int                exp_idx;
  int                timeout_cycles;
  logic [31:0]       stall_rand;

  fetch_unit #(
    .FIFO_DEPTH (3)
  ) u_fetch_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_en_i    (fetch_en_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .pc_o          (pc_o),
    .compressed_o  (compressed_o),
    .instr_ready_i (instr_ready_i),
    .busy_o        (busy_o),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_gnt_i    (imem_gnt_i),
    .imem_rvalid_i (imem_rvalid_i),
    .imem_rdata_i  (imem_rdata_i)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // image words, outside the image a pattern of the full address
  function automatic fetch_pkg::word_t mem_word(input fetch_pkg::addr_t a);
    int idx;
    idx = int'(a >> 2);
    if (idx < n_img) begin
      return image[idx];
    end
    return ~a;
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_instr(input string name, input fetch_pkg::instr_t exp,
                             input fetch_pkg::instr_t act);
    if (act !== exp) begin
      $display("Error: time %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_pc(input string name, input fetch_pkg::addr_t exp,
                          input fetch_pkg::addr_t act);
    if (act !== exp) begin
      $display("Error: time %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input bit act);
    if (act !== exp) begin
      $display("Error: time %0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // image count, image, record count, then target, count and pc/instr pairs
  task automatic load_stimulus();
    int ptr;
    int n_rec;
    int cnt;
    $readmemh("verif/fetch_stimulus.txt", stim);
    n_img = int'(stim[0]);
    for (int i = 0; i < n_img; i++) begin
      image[i] = stim[1 + i];
    end
    ptr   = 1 + n_img;
    n_rec = int'(stim[ptr]);
    ptr++;
    for (int r = 0; r < n_rec; r++) begin
      rec_target.push_back(stim[ptr]);
      cnt = int'(stim[ptr + 1]);
      rec_count.push_back(cnt);
      ptr += 2;
      repeat (cnt) begin
        exp_pc.push_back(stim[ptr]);
        exp_instr.push_back(stim[ptr + 1]);
        ptr += 2;
      end
    end
    if (n_rec == 0) begin
      $display("stimulus file holds no branch records");
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // clock, memory model, watchdog
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // answer first at +1, then grant at +2 once req has settled on it
  initial begin : memory_model
    logic [31:0]      bus_rand;
    int               gnt_wait;
    int               rv_wait;
    logic             pending;
    fetch_pkg::addr_t pend_addr;
    imem_gnt_i    = 1'b0;
    imem_rvalid_i = 1'b0;
    imem_rdata_i  = '0;
    bus_rand      = LCG_SEED;
    gnt_wait      = -1;
    rv_wait       = 0;
    pending       = 1'b0;
    pend_addr     = '0;
    forever begin
      @(posedge clk);
      #1;
      imem_rvalid_i = 1'b0;
      if (pending) begin
        rv_wait--;
        if (rv_wait == 0) begin
          imem_rvalid_i = 1'b1;
          imem_rdata_i  = mem_word(pend_addr);
          pending       = 1'b0;
        end
      end
      #1;
      imem_gnt_i = 1'b0;
      // a granted access still owes its word, so the fetch unit is busy
      if (pending) begin
        check_flag("busy_o", 1'b1, busy_o);
      end
      if (imem_req_o && pending) begin
        $display("request issued while a response is still outstanding");
        abort_run();
      end
      if (imem_req_o) begin
        if (gnt_wait < 0) begin
          bus_rand = lcg_step(bus_rand);
          gnt_wait = int'(bus_rand[31:16] % 16'd3);
        end
        if (gnt_wait == 0) begin
          imem_gnt_i = 1'b1;
          pending    = 1'b1;
          pend_addr  = imem_addr_o;
          bus_rand   = lcg_step(bus_rand);
          rv_wait    = 1 + int'(bus_rand[31:16] % 16'd2);
          gnt_wait   = -1;
        end else begin
          gnt_wait--;
        end
      end else begin
        gnt_wait = -1;
      end
    end
  end

  initial begin : watchdog
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge clk);
    $display("watchdog expired, only %0d of %0d instructions arrived",
             exp_idx, exp_pc.size());
    abort_run();
  end

  ////////////////////////////////////////
  // stimulus and checks
  ////////////////////////////////////////

  initial begin : main
    fetch_pkg::addr_t  held_pc;
    fetch_pkg::instr_t held_instr;
    logic              held;
    int                got;
    rst_n         = 1'b0;
    fetch_en_i    = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    instr_ready_i = 1'b1;
    stall_rand    = LCG_SEED;
    exp_idx       = 0;
    held_pc       = '0;
    held_instr    = '0;
    load_stimulus();
    timeout_cycles = 200 * exp_pc.size() + 40;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // fetch still disabled, bus and output stay quiet
    repeat (8) begin
      @(negedge clk);
      check_flag("imem_req_o", 1'b0, imem_req_o);
      check_flag("busy_o", 1'b0, busy_o);
      check_flag("instr_valid_o", 1'b0, instr_valid_o);
    end
    @(posedge clk);
    #1;
    foreach (rec_target[r]) begin
      // branch pulse right after the last accepted instruction
      fetch_en_i    = 1'b1;
      branch_i      = 1'b1;
      branch_addr_i = rec_target[r];
      held          = 1'b0;
      got           = 0;
      while (got < rec_count[r]) begin
        @(negedge clk);
        // a stalled instruction must not move
        if (held) begin
          check_flag("instr_valid_o", 1'b1, instr_valid_o);
          check_instr("instr_o", held_instr, instr_o);
          check_pc("pc_o", held_pc, pc_o);
        end
        held = 1'b0;
        if (instr_valid_o && instr_ready_i) begin
          check_pc("pc_o", exp_pc[exp_idx], pc_o);
          check_instr("instr_o", exp_instr[exp_idx], instr_o);
          check_flag("compressed_o", exp_instr[exp_idx][1:0] != 2'b11, compressed_o);
          exp_idx++;
          got++;
        end else if (instr_valid_o) begin
          held       = 1'b1;
          held_instr = instr_o;
          held_pc    = pc_o;
        end
        @(posedge clk);
        #1;
        branch_i = 1'b0;
        // ready low about one cycle in four
        stall_rand    = lcg_step(stall_rand);
        instr_ready_i = (stall_rand[31:30] != 2'b00);
      end
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== src.f ====
hdl/fetch_pkg.sv
hdl/fifo_in_if.sv
hdl/fetch_out_if.sv
hdl/fetch_fifo.sv
hdl/prefetch_buffer.sv
hdl/instr_aligner.sv
hdl/fetch_unit.sv
verif/fetch_unit_sva.sv
verif/fetch_unit_tb.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert --top-module fetch_unit_tb -f src.f
	out=$$(./obj_dir/Vfetch_unit_tb); echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== verif/fetch_stimulus.txt ====
// image word count, image words from byte address 0, record count, then per record:
// target and instruction count, followed by pairs of expected pc and instruction
0000000a
00a00093 00108113 002101b3 00318233   // 0x00 straight 32-bit run
05854505 03134601 068500c3 00e38393   // 0x10 mixed, straddle at 0x16
04134701 80820104                     // 0x20 straddle at 0x22
00000006
00000000 00000004                     // word aligned start
00000000 00a00093 00000004 00108113
00000008 002101b3 0000000c 00318233
00000010 00000009                     // compressed and full mix
00000010 00004505 00000012 00000585
00000014 00004601 00000016 00c30313
0000001a 00000685 0000001c 00e38393
00000020 00004701 00000022 01040413
00000026 00008082
00000012 00000004                     // upper half target
00000012 00000585 00000014 00004601
00000016 00c30313 0000001a 00000685
00000022 00000002                     // upper half, straddles at once
00000022 01040413 00000026 00008082
00000004 00000001                     // short run, fetch still in flight
00000004 00108113
0000001a 00000003
0000001a 00000685 0000001c 00e38393
00000020 00004701
